//--- design/cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// SRAM geometry
`define ADDR_W 12
`define DATA_W 16

// Datapath widths
`define PIX_W 8
`define ACC_W 20

// Kernel and window shape
`define KERNEL_TAPS 9
`define WIN_WORDS 8

// Size word that ends a run
`define END_MARKER 16'hFFFF

// Upper bound of the clamped ReLU
`define RELU_MAX 127

`endif

//--- design/cnn_pkg.sv
`default_nettype none

`include "cnn_defines.svh"

package cnn_pkg;

	// --------------------------------------------------
	// Bus and datapath types
	// --------------------------------------------------
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] word_t;
	typedef logic signed [`PIX_W-1:0] pixel_t;
	typedef logic signed [`ACC_W-1:0] acc_t;

	// Sums at offsets (0,0), (0,1), (1,0), (1,1)
	typedef acc_t [3:0] acc_quad_t;

	// --------------------------------------------------
	// FSM encodings
	// --------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,
		READ_SIZE,
		CHECK_SIZE,
		READ_WINDOW,
		WAIT_WINDOW,
		DRAIN
	} fetch_state_t;

	typedef enum logic [1:0] {
		EMPTY,
		FILL,
		MAC,
		DONE
	} conv_state_t;

endpackage

`default_nettype wire

//--- design/window_if.sv
`default_nettype none

interface window_if;

	// Fetch side
	logic start;
	logic data_valid;
	logic last;

	// Convolution side
	logic window_done;

	modport fetch (
		output start,
		output data_valid,
		output last,
		input  window_done
	);

	modport conv (
		input  start,
		input  data_valid,
		input  last,
		output window_done
	);

endinterface

`default_nettype wire

//--- design/window_fetch.sv
`default_nettype none

`include "cnn_defines.svh"

module window_fetch (
	input  logic           clk,
	input  logic           reset_b,
	input  logic           run,
	output logic           busy,
	output cnn_pkg::addr_t input_sram_read_address,
	input  cnn_pkg::word_t input_sram_read_data,
	window_if.fetch        win,
	input  logic           pending
);

	cnn_pkg::fetch_state_t state;
	cnn_pkg::fetch_state_t state_next;

	cnn_pkg::addr_t base_addr;
	cnn_pkg::addr_t row_addr;
	cnn_pkg::addr_t row_off;
	cnn_pkg::addr_t win_addr;
	cnn_pkg::addr_t matrix_step;

	logic [`PIX_W-1:0] n_size;
	logic [`PIX_W-2:0] half_n;
	logic [`PIX_W-2:0] win_row;
	logic [`PIX_W-2:0] win_col;
	logic [2:0]        word_cnt;
	logic              last_win;
	logic              is_end;

	assign half_n = n_size[`PIX_W-1:1];
	assign is_end = (input_sram_read_data == `END_MARKER);
	assign last_win = (win_row == half_n - 7'd2) && (win_col == half_n - 7'd2);

	// N*N/2 data words plus the size word
	assign matrix_step = cnn_pkg::addr_t'(n_size) * cnn_pkg::addr_t'(half_n) + 1'b1;

	// --------------------------------------------------
	// Window addressing
	// --------------------------------------------------
	// Two words per row, four rows, row stride N/2
	always_comb begin
		case (word_cnt[2:1])
			2'd0: row_off = '0;
			2'd1: row_off = cnn_pkg::addr_t'(half_n);
			2'd2: row_off = cnn_pkg::addr_t'(n_size);
			default: row_off = cnn_pkg::addr_t'(n_size) + cnn_pkg::addr_t'(half_n);
		endcase
		win_addr = row_addr + cnn_pkg::addr_t'(win_col) + row_off
			+ cnn_pkg::addr_t'(word_cnt[0]);
	end

	assign input_sram_read_address = (state == cnn_pkg::READ_WINDOW) ? win_addr : base_addr;
	assign win.start = (state == cnn_pkg::READ_WINDOW) && (word_cnt == '0);
	assign busy = (state != cnn_pkg::IDLE);

	// --------------------------------------------------
	// Control FSM
	// --------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			cnn_pkg::IDLE: if (run) state_next = cnn_pkg::READ_SIZE;
			cnn_pkg::READ_SIZE: state_next = cnn_pkg::CHECK_SIZE;
			cnn_pkg::CHECK_SIZE: begin
				state_next = is_end ? cnn_pkg::DRAIN : cnn_pkg::READ_WINDOW;
			end
			cnn_pkg::READ_WINDOW: begin
				if (word_cnt == `WIN_WORDS - 1) state_next = cnn_pkg::WAIT_WINDOW;
			end
			cnn_pkg::WAIT_WINDOW: begin
				if (win.window_done) begin
					state_next = last_win ? cnn_pkg::READ_SIZE : cnn_pkg::READ_WINDOW;
				end
			end
			default: if (!pending) state_next = cnn_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= cnn_pkg::IDLE;
			base_addr <= '0;
			row_addr <= '0;
			word_cnt <= '0;
			win_row <= '0;
			win_col <= '0;
			win.data_valid <= 1'b0;
			win.last <= 1'b0;
		end else begin
			state <= state_next;
			// Read data lands one cycle after the address
			win.data_valid <= (state == cnn_pkg::READ_WINDOW);
			win.last <= (state == cnn_pkg::READ_WINDOW) && last_win;
			case (state)
				cnn_pkg::CHECK_SIZE: begin
					row_addr <= base_addr + 1'b1;
					win_row <= '0;
					win_col <= '0;
				end
				cnn_pkg::READ_WINDOW: word_cnt <= word_cnt + 1'b1;
				cnn_pkg::WAIT_WINDOW: begin
					if (win.window_done) begin
						if (last_win) begin
							base_addr <= base_addr + matrix_step;
						end else if (win_col == half_n - 7'd2) begin
							// Two pixel rows down is N words
							win_col <= '0;
							win_row <= win_row + 1'b1;
							row_addr <= row_addr + cnn_pkg::addr_t'(n_size);
						end else begin
							win_col <= win_col + 1'b1;
						end
					end
				end
				cnn_pkg::DRAIN: if (!pending) base_addr <= '0;
				default: ;
			endcase
		end
	end

	// Matrix size from the low byte of the size word
	always_ff @(posedge clk) begin
		if (state == cnn_pkg::CHECK_SIZE) n_size <= input_sram_read_data[`PIX_W-1:0];
	end

	// A new window never overlaps data of the previous one
	assert property (@(posedge clk) disable iff (!reset_b)
		win.start |-> (state == cnn_pkg::READ_WINDOW) && !win.data_valid)
		else $error("window start outside READ_WINDOW");

endmodule

`default_nettype wire

//--- design/conv_engine.sv
`default_nettype none

`include "cnn_defines.svh"

module conv_engine (
	input  logic               clk,
	input  logic               reset_b,
	window_if.conv             win,
	input  cnn_pkg::word_t     input_sram_read_data,
	output cnn_pkg::addr_t     weights_sram_read_address,
	input  cnn_pkg::word_t     weights_sram_read_data,
	output logic               result_valid,
	output cnn_pkg::acc_quad_t result,
	output logic               result_last
);

	cnn_pkg::conv_state_t state;

	// 4x4 window, row-major, one byte per entry
	cnn_pkg::pixel_t pix_buf [2*`WIN_WORDS];
	cnn_pkg::acc_t   acc [4];
	cnn_pkg::pixel_t weight;

	logic [3:0] fill_cnt;
	logic [3:0] tap;
	logic [1:0] k_row;
	logic [1:0] k_col;
	logic [3:0] pix_base;
	logic       last_q;

	// --------------------------------------------------
	// Weight sequencing
	// --------------------------------------------------
	// Address runs one tap ahead so word 0 goes out during FILL
	assign weights_sram_read_address = (state == cnn_pkg::MAC) ?
		cnn_pkg::addr_t'((tap + 4'd1) >> 1) : '0;

	// Even taps low byte, odd taps high byte
	assign weight = tap[0] ? weights_sram_read_data[2*`PIX_W-1:`PIX_W] :
		weights_sram_read_data[`PIX_W-1:0];

	assign pix_base = {k_row, 2'b00} + {2'b00, k_col};

	assign result_valid = (state == cnn_pkg::DONE);
	assign win.window_done = (state == cnn_pkg::DONE);
	assign result_last = (state == cnn_pkg::DONE) && last_q;

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= cnn_pkg::EMPTY;
			fill_cnt <= '0;
			tap <= '0;
			k_row <= '0;
			k_col <= '0;
		end else begin
			// Counts every word since start including stray ones
			if (win.start) begin
				fill_cnt <= '0;
			end else if (win.data_valid) begin
				fill_cnt <= fill_cnt + 1'b1;
			end

			if (state == cnn_pkg::MAC) begin
				tap <= tap + 1'b1;
				if (k_col == 2'd2) begin
					k_col <= '0;
					k_row <= k_row + 1'b1;
				end else begin
					k_col <= k_col + 1'b1;
				end
			end else begin
				tap <= '0;
				k_row <= '0;
				k_col <= '0;
			end

			case (state)
				cnn_pkg::EMPTY: if (win.start) state <= cnn_pkg::FILL;
				cnn_pkg::FILL: begin
					if (win.data_valid && fill_cnt == `WIN_WORDS - 1) state <= cnn_pkg::MAC;
				end
				cnn_pkg::MAC: if (tap == `KERNEL_TAPS - 1) state <= cnn_pkg::DONE;
				default: state <= cnn_pkg::EMPTY;
			endcase
		end
	end

	// --------------------------------------------------
	// Window buffer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == cnn_pkg::FILL && win.data_valid) begin
			pix_buf[{fill_cnt[2:0], 1'b0}] <= input_sram_read_data[`PIX_W-1:0];
			pix_buf[{fill_cnt[2:0], 1'b1}] <= input_sram_read_data[2*`PIX_W-1:`PIX_W];
			last_q <= win.last;
		end
	end

	// --------------------------------------------------
	// Four multiply-accumulates, one per output offset
	// --------------------------------------------------
	for (genvar g = 0; g < 4; g++) begin : g_mac
		localparam int OFF = (g % 2) + 4 * (g / 2);

		logic signed [2*`PIX_W-1:0] prod;

		assign prod = pix_buf[pix_base + OFF] * weight;
		assign result[g] = acc[g];

		always_ff @(posedge clk) begin
			if (win.start) begin
				acc[g] <= '0;
			end else if (state == cnn_pkg::MAC) begin
				acc[g] <= acc[g] + cnn_pkg::acc_t'(prod);
			end
		end
	end

	// Fetch must hold off until window_done
	assert property (@(posedge clk) disable iff (!reset_b)
		win.data_valid |-> state != cnn_pkg::MAC)
		else $error("window data during MAC");

	assert property (@(posedge clk) disable iff (!reset_b)
		state == cnn_pkg::DONE |-> fill_cnt == `WIN_WORDS)
		else $error("wrong word count for window");

endmodule

`default_nettype wire

//--- design/output_writer.sv
`default_nettype none

`include "cnn_defines.svh"

module output_writer (
	input  logic               clk,
	input  logic               reset_b,
	input  logic               busy,
	input  logic               result_valid,
	input  cnn_pkg::acc_quad_t result,
	input  logic               result_last,
	output logic               pending,
	output logic               output_sram_write_enable,
	output cnn_pkg::addr_t     output_sram_write_address,
	output cnn_pkg::word_t     output_sram_write_data
);

	cnn_pkg::acc_quad_t res_q;
	cnn_pkg::acc_t      max_lo;
	cnn_pkg::acc_t      max_hi;
	cnn_pkg::acc_t      max_all;
	cnn_pkg::addr_t     next_addr;

	logic [`PIX_W-1:0] relu_byte;
	logic [`PIX_W-1:0] first_byte;
	logic              valid_q;
	logic              last_q;
	logic              have_first;
	logic              do_write;

	// --------------------------------------------------
	// Max pool and clamped ReLU
	// --------------------------------------------------
	always_comb begin
		max_lo = ($signed(res_q[0]) > $signed(res_q[1])) ? res_q[0] : res_q[1];
		max_hi = ($signed(res_q[2]) > $signed(res_q[3])) ? res_q[2] : res_q[3];
		max_all = (max_lo > max_hi) ? max_lo : max_hi;
		if (max_all < 0) begin
			relu_byte = '0;
		end else if (max_all > cnn_pkg::acc_t'(`RELU_MAX)) begin
			relu_byte = `PIX_W'(`RELU_MAX);
		end else begin
			relu_byte = max_all[`PIX_W-1:0];
		end
	end

	// Second byte of a pair, or a lone byte at matrix end
	assign do_write = valid_q && (have_first || last_q);
	assign pending = result_valid || valid_q || output_sram_write_enable;

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			valid_q <= 1'b0;
			have_first <= 1'b0;
			output_sram_write_enable <= 1'b0;
			next_addr <= '0;
		end else begin
			valid_q <= result_valid;
			output_sram_write_enable <= do_write;
			if (valid_q) have_first <= !have_first && !last_q;
			if (do_write) next_addr <= next_addr + 1'b1;
			if (!busy) begin
				have_first <= 1'b0;
				next_addr <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		res_q <= result;
		last_q <= result_last;
		if (valid_q && !have_first) first_byte <= relu_byte;
		if (do_write) begin
			output_sram_write_address <= next_addr;
			// First byte of a pair sits in the high half
			output_sram_write_data <= have_first ? {first_byte, relu_byte} :
				{relu_byte, {`PIX_W{1'b0}}};
		end
	end

	// Address counter only moves forward within a run
	assert property (@(posedge clk) disable iff (!reset_b)
		busy && $past(busy) |-> next_addr >= $past(next_addr))
		else $error("output address wrapped during run");

endmodule

`default_nettype wire

//--- design/cnn_top.sv
`default_nettype none

module cnn_top (
	input  logic           clk,
	input  logic           reset_b,
	input  logic           run,
	output logic           busy,

	// Input SRAM
	output cnn_pkg::addr_t input_sram_read_address,
	input  cnn_pkg::word_t input_sram_read_data,

	// Weights SRAM
	output cnn_pkg::addr_t weights_sram_read_address,
	input  cnn_pkg::word_t weights_sram_read_data,

	// Output SRAM
	output logic           output_sram_write_enable,
	output cnn_pkg::addr_t output_sram_write_address,
	output cnn_pkg::word_t output_sram_write_data
);

	cnn_pkg::acc_quad_t result;
	logic               result_valid;
	logic               result_last;
	logic               pending;

	window_if win_bus ();

	window_fetch u_fetch (
		.clk                     (clk),
		.reset_b                 (reset_b),
		.run                     (run),
		.busy                    (busy),
		.input_sram_read_address (input_sram_read_address),
		.input_sram_read_data    (input_sram_read_data),
		.win                     (win_bus.fetch),
		.pending                 (pending)
	);

	conv_engine u_conv (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.win                       (win_bus.conv),
		.input_sram_read_data      (input_sram_read_data),
		.weights_sram_read_address (weights_sram_read_address),
		.weights_sram_read_data    (weights_sram_read_data),
		.result_valid              (result_valid),
		.result                    (result),
		.result_last               (result_last)
	);

	output_writer u_writer (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.busy                      (busy),
		.result_valid              (result_valid),
		.result                    (result),
		.result_last               (result_last),
		.pending                   (pending),
		.output_sram_write_enable  (output_sram_write_enable),
		.output_sram_write_address (output_sram_write_address),
		.output_sram_write_data    (output_sram_write_data)
	);

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset_b
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Release on a falling edge away from the sampling edge
	initial begin
		reset_b = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_b = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/sram_model.sv
`default_nettype none

module sram_model #(
	parameter int DEPTH = 4096,
	parameter int LOG_DEPTH = 256
) (
	input  logic           clk,
	input  logic           write_enable,
	input  cnn_pkg::addr_t write_address,
	input  cnn_pkg::word_t write_data,
	input  cnn_pkg::addr_t read_address,
	output cnn_pkg::word_t read_data
);
	timeunit 1ns;
	timeprecision 1ps;

	cnn_pkg::word_t mem [DEPTH];

	// Every write in order of arrival
	cnn_pkg::addr_t log_address [LOG_DEPTH];
	cnn_pkg::word_t log_data [LOG_DEPTH];
	int             write_count;

	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
			if (write_count < LOG_DEPTH) begin
				log_address[write_count] <= write_address;
				log_data[write_count] <= write_data;
			end
			write_count <= write_count + 1;
		end
		// Read data comes one cycle after the address
		read_data <= mem[read_address];
	end

endmodule

`default_nettype wire

//--- tb/tb_top.sv
`default_nettype none

`include "cnn_defines.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	// Total windows of all tests are 1 + 9 + (1 + 4 + 1) + 1
	localparam int TOTAL_WINDOWS = 17;
	localparam int LOAD_WORDS = 130;
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_NS =
		(TOTAL_WINDOWS * 30 + LOAD_WORDS + MARGIN_CYCLES) * CLK_PERIOD;

	logic clk;
	logic reset_b;
	logic run;
	logic busy;
	logic in_we;
	logic w_we;
	logic out_we;
	cnn_pkg::addr_t in_ra, in_wa, w_ra, w_wa, out_wa;
	cnn_pkg::word_t in_rd, in_wd, w_rd, w_wd, out_wd;

	// Stimulus and reference model state
	logic signed [7:0] pixels [64][64];
	logic signed [7:0] kernel [9];
	cnn_pkg::word_t    image [$];
	cnn_pkg::word_t    expected [$];
	int                seed;
	int                checks;
	int                mismatches;
	int                failures;

	clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clock0 (.clk(clk), .reset_b(reset_b));

	cnn_top dut0 (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.run                       (run),
		.busy                      (busy),
		.input_sram_read_address   (in_ra),
		.input_sram_read_data      (in_rd),
		.weights_sram_read_address (w_ra),
		.weights_sram_read_data    (w_rd),
		.output_sram_write_enable  (out_we),
		.output_sram_write_address (out_wa),
		.output_sram_write_data    (out_wd)
	);

	sram_model input_mem (.clk(clk), .write_enable(in_we), .write_address(in_wa),
		.write_data(in_wd), .read_address(in_ra), .read_data(in_rd));
	sram_model weights_mem (.clk(clk), .write_enable(w_we), .write_address(w_wa),
		.write_data(w_wd), .read_address(w_ra), .read_data(w_rd));
	sram_model output_mem (.clk(clk), .write_enable(out_we), .write_address(out_wa),
		.write_data(out_wd), .read_address('0), .read_data());

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic int kernel_sum();
		int s;
		s = 0;
		for (int t = 0; t < 9; t++) s += int'(kernel[t]);
		return s;
	endfunction

	// Max of the four 3x3 sums, then ReLU clamped to 0..127
	function automatic logic [7:0] window_result(input int r, input int c);
		int best;
		int sum;
		best = -(1 << 30);
		for (int dy = 0; dy < 2; dy++) begin
			for (int dx = 0; dx < 2; dx++) begin
				sum = 0;
				for (int t = 0; t < 9; t++) begin
					sum += int'(kernel[t]) * int'(pixels[r + dy + t / 3][c + dx + t % 3]);
				end
				if (sum > best) best = sum;
			end
		end
		if (best < 0) return 8'd0;
		if (best > `RELU_MAX) return 8'd127;
		return 8'(best);
	endfunction

	function automatic void make_center_kernel();
		for (int t = 0; t < 9; t++) kernel[t] = (t == 4) ? 8'sd1 : 8'sd0;
	endfunction

	// Kernel sum kept away from zero so constant corners clamp both ways
	function automatic void make_random_kernel();
		do begin
			for (int t = 0; t < 9; t++) kernel[t] = 8'($random(seed));
		end while (kernel_sum() >= -1 && kernel_sum() <= 1);
	endfunction

	// Appends one matrix to the image and its packed results to expected
	function automatic void add_matrix(input int n, input bit corners);
		logic [7:0]        results [$];
		logic signed [7:0] corner_val;
		corner_val = (kernel_sum() > 0) ? 8'sd100 : -8'sd100;
		image.push_back(16'(n));
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				pixels[r][c] = 8'($random(seed));
				if (corners && r < 4 && c < 4) pixels[r][c] = corner_val;
				if (corners && r >= n - 4 && c >= n - 4) pixels[r][c] = -corner_val;
			end
			for (int c = 0; c < n; c += 2) image.push_back({pixels[r][c + 1], pixels[r][c]});
		end
		for (int wr = 0; wr <= n - 4; wr += 2) begin
			for (int wc = 0; wc <= n - 4; wc += 2) results.push_back(window_result(wr, wc));
		end
		for (int k = 0; k < results.size(); k += 2) begin
			if (k + 1 < results.size()) begin
				expected.push_back({results[k], results[k + 1]});
			end else begin
				expected.push_back({results[k], 8'h00});
			end
		end
	endfunction

	// --------------------------------------------------
	// Drivers and checks
	// --------------------------------------------------
	task automatic check_value(input string name, input string what,
		input int exp_val, input int act_val);
		checks++;
		assert (exp_val == act_val) else begin
			mismatches++;
			$display("MISMATCH %s %s expected 0x%0h actual 0x%0h", name, what, exp_val, act_val);
		end
	endtask

	task automatic write_word(input bit to_weights, input cnn_pkg::addr_t addr,
		input cnn_pkg::word_t data);
		@(negedge clk);
		in_we = !to_weights;
		w_we = to_weights;
		in_wa = addr;
		w_wa = addr;
		in_wd = data;
		w_wd = data;
	endtask

	task automatic load_memories();
		for (int i = 0; i < image.size(); i++) write_word(1'b0, cnn_pkg::addr_t'(i), image[i]);
		write_word(1'b0, cnn_pkg::addr_t'(image.size()), `END_MARKER);
		for (int k = 0; k < 4; k++) begin
			write_word(1'b1, cnn_pkg::addr_t'(k), {kernel[2 * k + 1], kernel[2 * k]});
		end
		write_word(1'b1, cnn_pkg::addr_t'(4), {8'h00, kernel[8]});
		@(negedge clk);
		in_we = 1'b0;
		w_we = 1'b0;
	endtask

	task automatic run_and_check(input string name);
		int first;
		int count;
		first = output_mem.write_count;
		@(negedge clk);
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
		checks++;
		assert (busy) else begin
			failures++;
			$display("%s: busy did not rise the cycle after run", name);
		end
		while (busy) @(negedge clk);
		count = output_mem.write_count - first;
		check_value(name, "write count", expected.size(), count);
		for (int k = 0; k < count && k < expected.size(); k++) begin
			check_value(name, $sformatf("address of write %0d", k), k,
				int'(output_mem.log_address[first + k]));
			check_value(name, $sformatf("data of write %0d", k), int'(expected[k]),
				int'(output_mem.log_data[first + k]));
		end
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic idle_after_reset();
		repeat (10) begin
			@(negedge clk);
			checks++;
			assert (!busy && !out_we) else begin
				failures++;
				$display("idle_after_reset: busy or write enable high while run is low");
			end
		end
	endtask

	task automatic single_matrix(input string name);
		image.delete();
		expected.delete();
		make_center_kernel();
		add_matrix(4, 1'b0);
		load_memories();
		run_and_check(name);
	endtask

	task automatic random_8x8();
		image.delete();
		expected.delete();
		make_random_kernel();
		add_matrix(8, 1'b1);
		load_memories();
		run_and_check("random_8x8");
	endtask

	task automatic three_matrices();
		image.delete();
		expected.delete();
		make_random_kernel();
		add_matrix(4, 1'b0);
		add_matrix(6, 1'b0);
		add_matrix(4, 1'b0);
		load_memories();
		run_and_check("three_matrices");
	endtask

	task automatic end_marker_only();
		image.delete();
		expected.delete();
		load_memories();
		run_and_check("end_marker_only");
		single_matrix("after_end_marker");
	endtask

	initial begin
		seed = 62;
		checks = 0;
		mismatches = 0;
		failures = 0;
		run = 1'b0;
		in_we = 1'b0;
		w_we = 1'b0;
		in_wa = '0;
		w_wa = '0;
		in_wd = '0;
		w_wd = '0;
		@(posedge reset_b);
		idle_after_reset();
		single_matrix("single_4x4");
		random_8x8();
		three_matrices();
		end_marker_only();
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/cnn_pkg.sv
design/window_if.sv
design/window_fetch.sv
design/conv_engine.sv
design/output_writer.sv
design/cnn_top.sv
tb/clock_gen.sv
tb/sram_model.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module tb_top -o sim_tb

# A failing run still reaches the search below
output=$(./obj_dir/sim_tb || true)
echo "$output"

echo "$output" | grep -q "^Everything OK$"
